//--- flist.f
design/scope_pkg.sv
design/pix_wr_if.sv
design/scope_regs.sv
design/point_plotter.sv
design/fb_clear.sv
design/fb_arbiter.sv
design/fb_mem.sv
design/raster_scan.sv
design/scope_top.sv
bench/tb_scope.sv

//--- run.sh
#!/usr/bin/env bash
set -e

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal -j 0 \
  --top-module tb_scope -f flist.f

# the simulator exits nonzero on $fatal, tee keeps the pipeline going
./obj_dir/Vtb_scope 2>&1 | tee sim.log

if grep -q "ERRORS FOUND" sim.log; then
  echo "simulation failed"
  exit 1
fi

if ! grep -q "NO ERRORS" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi

echo "simulation passed"

//--- bench/tb_scope.sv
`timescale 1ns/1ps
`default_nettype none

module tb_scope;
  import scope_pkg::*;

  localparam int frame_cycles = h_total * v_total;
  // about 16 frames of test plus margin
  localparam int max_cycles = 20000;
  // last pixel before line 24
  localparam int frame_end_pos = fb_height * h_total - 1;
  // keep samples away from a frame end to cover write latency and the swap edge
  localparam int guard_lo = frame_end_pos - 11;
  localparam int guard_hi = frame_end_pos + 2;
  localparam logic [31:0] rand_seed = 32'h52e79ed9;

  logic                     clk;
  logic                     reset;
  logic [apb_addr_bits-1:0] paddr;
  logic                     psel;
  logic                     penable;
  logic                     pwrite;
  logic [apb_data_bits-1:0] pwdata;
  logic [apb_data_bits-1:0] prdata;
  logic                     pready;
  logic [adc_bits-1:0]      adc_x;
  logic [adc_bits-1:0]      adc_y;
  logic                     adc_valid;
  logic                     adc_ready;
  logic [color_bits-1:0]    vga_red;
  logic [color_bits-1:0]    vga_grn;
  logic [color_bits-1:0]    vga_blu;
  logic                     vga_hsync;
  logic                     vga_vsync;
  logic                     vga_de;

  // reference model of both banks, the raster and the clear sweep
  pixel_t                  model_fb [2][fb_pixels];
  logic                    front_sel;
  logic                    front_known;
  logic                    disp_en;
  logic                    swap_pending;
  logic                    ready_prev;
  int                      pos;
  int                      frames_seen;
  int                      clear_left;
  int                      timeout_cycles;
  pixel_t                  plot_model;
  pixel_t                  bg_model;
  logic [persist_bits-1:0] persist_model;

  scope_top scope_top_inst (
    .clk      (clk),
    .reset    (reset),
    .paddr    (paddr),
    .psel     (psel),
    .penable  (penable),
    .pwrite   (pwrite),
    .pwdata   (pwdata),
    .prdata   (prdata),
    .pready   (pready),
    .adc_x    (adc_x),
    .adc_y    (adc_y),
    .adc_valid(adc_valid),
    .adc_ready(adc_ready),
    .vga_red  (vga_red),
    .vga_grn  (vga_grn),
    .vga_blu  (vga_blu),
    .vga_hsync(vga_hsync),
    .vga_vsync(vga_vsync),
    .vga_de   (vga_de)
  );

  task automatic expect_equal(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
    assert (actual === expected) else begin
      $display("ERRORS FOUND");
      $display("FAIL %s: got 0x%h, expected 0x%h", name, actual, expected);
      $fatal(1, "wrong value on %s", name);
    end
  endtask

  task automatic fill_bank(input logic bank, input pixel_t color);
    for (int i = 0; i < fb_pixels; i++) begin
      model_fb[bank][i] = color;
    end
  endtask

  function automatic int persist_eff();
    return (persist_model == '0) ? 1 : int'(persist_model);
  endfunction

  // check the outputs of the edge just passed and advance the model by one clock
  task automatic tick();
    int     h;
    int     v;
    int     sx;
    int     sy;
    logic   visible;
    logic   flip;
    pixel_t shown;
    @(negedge clk);
    h       = pos % h_total;
    v       = pos / h_total;
    visible = (h < fb_width) && (v < fb_height);
    shown   = {vga_red, vga_grn, vga_blu};
    expect_equal("vga_de", 32'(vga_de), 32'(visible));
    expect_equal("vga_hsync", 32'(vga_hsync),
                 32'(!(h >= hsync_start && h < hsync_start + hsync_len)));
    expect_equal("vga_vsync", 32'(vga_vsync),
                 32'(!(v >= vsync_start && v < vsync_start + vsync_len)));
    if (!(visible && disp_en)) begin
      expect_equal("vga_rgb", 32'(shown), 32'h0);
    end else if (front_known) begin
      expect_equal("vga_rgb", 32'(shown), 32'(model_fb[front_sel][v * fb_width + h]));
    end

    // sample taken on this edge ends up in the back bank
    if (adc_valid && ready_prev) begin
      sx = int'(adc_x) >> adc_shift;
      sy = int'(adc_y) >> adc_shift;
      if (sy < fb_height) begin
        model_fb[~front_sel][sy * fb_width + sx] = plot_model;
      end
    end

    flip         = swap_pending;
    swap_pending = 1'b0;
    if (pos == frame_end_pos) begin
      frames_seen++;
      if (frames_seen >= persist_eff()) begin
        swap_pending = 1'b1;
        frames_seen  = 0;
      end
    end
    if (clear_left > 0) begin
      clear_left--;
      if (clear_left == 0) begin
        disp_en = 1'b1;
      end
    end
    if (flip) begin
      front_sel   = ~front_sel;
      front_known = 1'b1;
      fill_bank(~front_sel, bg_model);
      clear_left  = fb_pixels;
    end
    pos = (pos + 1) % frame_cycles;

    expect_equal("adc_ready", 32'(adc_ready), 32'(clear_left == 0));
    ready_prev = (clear_left == 0);
  endtask

  task automatic drive_sample();
    if ((pos < guard_lo || pos > guard_hi) && $urandom_range(3, 0) == 0) begin
      adc_valid = 1'b1;
      adc_x     = adc_bits'($urandom_range(1023, 0));
      adc_y     = adc_bits'($urandom_range(1023, 0));
    end else begin
      adc_valid = 1'b0;
    end
  endtask

  task automatic run_cycles(input int n);
    repeat (n) begin
      drive_sample();
      tick();
    end
    adc_valid = 1'b0;
  endtask

  // drain the plotter and wait until no sweep runs and the frame end is far off
  task automatic safe_point();
    adc_valid = 1'b0;
    repeat (3) tick();
    while (clear_left != 0 || pos > 880) begin
      tick();
    end
  endtask

  task automatic apb_write(input logic [apb_addr_bits-1:0] addr, input logic [31:0] data);
    adc_valid = 1'b0;
    psel      = 1'b1;
    penable   = 1'b0;
    pwrite    = 1'b1;
    paddr     = addr;
    pwdata    = data;
    tick();
    penable = 1'b1;
    tick();
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    case (addr)
      reg_plot_color: plot_model = data[pixel_bits-1:0];
      reg_bg_color:   bg_model = data[pixel_bits-1:0];
      reg_persist:    persist_model = data[persist_bits-1:0];
      default: ;
    endcase
  endtask

  task automatic apb_read(input logic [apb_addr_bits-1:0] addr, input logic [31:0] expected);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    tick();
    penable = 1'b1;
    expect_equal("prdata", prdata, expected);
    expect_equal("pready", 32'(pready), 32'h1);
    tick();
    psel    = 1'b0;
    penable = 1'b0;
  endtask

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  initial begin
    timeout_cycles = 0;
    while (timeout_cycles < max_cycles) begin
      @(posedge clk);
      timeout_cycles++;
    end
    $display("ERRORS FOUND");
    $display("timeout, the test did not finish within %0d cycles", max_cycles);
    $fatal(1, "timeout");
  end

  initial begin
    int                       sel;
    logic [31:0]              data;
    logic [apb_addr_bits-1:0] addr;
    void'($urandom(rand_seed));
    reset     = 1'b1;
    paddr     = '0;
    psel      = 1'b0;
    penable   = 1'b0;
    pwrite    = 1'b0;
    pwdata    = '0;
    adc_x     = '0;
    adc_y     = '0;
    adc_valid = 1'b0;
    pos           = 0;
    frames_seen   = 0;
    clear_left    = fb_pixels;
    disp_en       = 1'b0;
    swap_pending  = 1'b0;
    front_sel     = 1'b0;
    front_known   = 1'b0;
    plot_model    = 12'hfff;
    bg_model      = 12'h000;
    persist_model = 3'd1;
    fill_bank(1'b0, 12'h000);
    // first sweep clears bank 1 with the reset background
    fill_bank(1'b1, bg_model);

    repeat (3) @(negedge clk);
    expect_equal("vga_hsync", 32'(vga_hsync), 32'h1);
    expect_equal("vga_vsync", 32'(vga_vsync), 32'h1);
    expect_equal("vga_rgb", 32'({vga_red, vga_grn, vga_blu}), 32'h0);
    expect_equal("adc_ready", 32'(adc_ready), 32'h0);
    ready_prev = 1'b0;
    reset      = 1'b0;

    // display stays dark through the first sweep
    while (clear_left != 0) begin
      tick();
    end

    apb_read(reg_plot_color, 32'hfff);
    apb_read(reg_bg_color, 32'h000);
    apb_read(reg_persist, 32'h1);
    for (int i = 0; i < 8; i++) begin
      sel  = int'($urandom_range(2, 0));
      addr = apb_addr_bits'(sel * 4);
      data = $urandom();
      apb_write(addr, data);
      apb_read(addr, (sel == 2) ? (data & 32'h7) : (data & 32'hfff));
    end
    apb_read(4'h2, 32'h0);
    apb_read(4'hc, 32'h0);
    apb_read(4'hf, 32'h0);
    apb_write(reg_persist, 32'd1);
    apb_write(reg_plot_color, 32'h800 | ($urandom() & 32'hfff));
    apb_write(reg_bg_color, $urandom() & 32'h777);

    // one frame per swap
    run_cycles(3 * frame_cycles);

    // colour change between frames
    safe_point();
    apb_write(reg_bg_color, $urandom() & 32'h777);
    apb_write(reg_plot_color, 32'h800 | ($urandom() & 32'hfff));
    run_cycles(2 * frame_cycles);

    // three frames per swap
    safe_point();
    apb_write(reg_persist, 32'd3);
    run_cycles(7 * frame_cycles);

    $display("NO ERRORS");
    $finish;
  end

endmodule

`default_nettype wire

//--- design/scope_top.sv
`timescale 1ns/1ps
`default_nettype none

module scope_top (
  input  logic                                clk,
  input  logic                                reset,

  // apb configuration
  input  logic [scope_pkg::apb_addr_bits-1:0] paddr,
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  logic [scope_pkg::apb_data_bits-1:0] pwdata,
  output logic [scope_pkg::apb_data_bits-1:0] prdata,
  output logic                                pready,

  // adc samples
  input  logic [     scope_pkg::adc_bits-1:0] adc_x,
  input  logic [     scope_pkg::adc_bits-1:0] adc_y,
  input  logic                                adc_valid,
  output logic                                adc_ready,

  // video out
  output logic [   scope_pkg::color_bits-1:0] vga_red,
  output logic [   scope_pkg::color_bits-1:0] vga_grn,
  output logic [   scope_pkg::color_bits-1:0] vga_blu,
  output logic                                vga_hsync,
  output logic                                vga_vsync,
  output logic                                vga_de
);
  import scope_pkg::*;

  pixel_t                  plot_color;
  pixel_t                  bg_color;
  logic [persist_bits-1:0] persist;

  logic     clear_busy;
  logic     display_en;
  logic     swap_req;
  logic     we;
  fb_addr_t waddr;
  pixel_t   wdata;
  fb_addr_t raddr;
  pixel_t   rdata;

  pix_wr_if clr_wr (.clk(clk));
  pix_wr_if plot_wr (.clk(clk));

  scope_regs scope_regs_inst (
    .clk       (clk),
    .reset     (reset),
    .paddr     (paddr),
    .psel      (psel),
    .penable   (penable),
    .pwrite    (pwrite),
    .pwdata    (pwdata),
    .prdata    (prdata),
    .pready    (pready),
    .plot_color(plot_color),
    .bg_color  (bg_color),
    .persist   (persist)
  );

  point_plotter point_plotter_inst (
    .clk       (clk),
    .reset     (reset),
    .adc_x     (adc_x),
    .adc_y     (adc_y),
    .adc_valid (adc_valid),
    .adc_ready (adc_ready),
    .plot_color(plot_color),
    .clear_busy(clear_busy),
    .wr        (plot_wr.writer)
  );

  // each swap kicks off a fresh clear of the new back bank
  fb_clear fb_clear_inst (
    .clk       (clk),
    .reset     (reset),
    .start     (swap_req),
    .bg_color  (bg_color),
    .busy      (clear_busy),
    .display_en(display_en),
    .wr        (clr_wr.writer)
  );

  fb_arbiter fb_arbiter_inst (
    .clr  (clr_wr.arbiter),
    .plot (plot_wr.arbiter),
    .we   (we),
    .waddr(waddr),
    .wdata(wdata)
  );

  fb_mem fb_mem_inst (
    .clk  (clk),
    .reset(reset),
    .swap (swap_req),
    .we   (we),
    .waddr(waddr),
    .wdata(wdata),
    .raddr(raddr),
    .rdata(rdata)
  );

  raster_scan raster_scan_inst (
    .clk       (clk),
    .reset     (reset),
    .persist   (persist),
    .display_en(display_en),
    .rdata     (rdata),
    .raddr     (raddr),
    .swap_req  (swap_req),
    .vga_red   (vga_red),
    .vga_grn   (vga_grn),
    .vga_blu   (vga_blu),
    .vga_hsync (vga_hsync),
    .vga_vsync (vga_vsync),
    .vga_de    (vga_de)
  );

endmodule

`default_nettype wire

//--- design/raster_scan.sv
`timescale 1ns/1ps
`default_nettype none

module raster_scan (
  input  logic                               clk,
  input  logic                               reset,
  input  logic [scope_pkg::persist_bits-1:0] persist,
  input  logic                               display_en,
  input  scope_pkg::pixel_t                  rdata,
  output scope_pkg::fb_addr_t                raddr,
  output logic                               swap_req,
  output logic [  scope_pkg::color_bits-1:0] vga_red,
  output logic [  scope_pkg::color_bits-1:0] vga_grn,
  output logic [  scope_pkg::color_bits-1:0] vga_blu,
  output logic                               vga_hsync,
  output logic                               vga_vsync,
  output logic                               vga_de
);
  import scope_pkg::*;

  logic [h_cnt_bits-1:0]   h_cnt;
  logic [v_cnt_bits-1:0]   v_cnt;
  logic [persist_bits-1:0] frame_cnt;
  logic [persist_bits-1:0] persist_eff;

  logic line_end;
  logic frame_end;
  logic visible;
  logic hsync_on;
  logic vsync_on;
  logic swap_due;

  assign line_end  = h_cnt == h_cnt_bits'(h_total - 1);
  // last pixel before line 24
  assign frame_end = line_end && (v_cnt == v_cnt_bits'(fb_height - 1));

  always_ff @(posedge clk) begin
    if (reset) begin
      h_cnt <= '0;
      v_cnt <= '0;
    end else if (line_end) begin
      h_cnt <= '0;
      if (v_cnt == v_cnt_bits'(v_total - 1)) begin
        v_cnt <= '0;
      end else begin
        v_cnt <= v_cnt + 1'b1;
      end
    end else begin
      h_cnt <= h_cnt + 1'b1;
    end
  end

  assign visible = (h_cnt < h_cnt_bits'(fb_width)) && (v_cnt < v_cnt_bits'(fb_height));

  // park the address during blanking to stay inside the bank
  assign raddr = visible ? {v_cnt[fb_y_bits-1:0], h_cnt[fb_x_bits-1:0]} : '0;

  assign hsync_on = (h_cnt >= h_cnt_bits'(hsync_start)) &&
                    (h_cnt < h_cnt_bits'(hsync_start + hsync_len));
  assign vsync_on = (v_cnt >= v_cnt_bits'(vsync_start)) &&
                    (v_cnt < v_cnt_bits'(vsync_start + vsync_len));

  // one cycle behind the counters, colour and timing together
  always_ff @(posedge clk) begin
    if (reset) begin
      vga_hsync <= 1'b1;
      vga_vsync <= 1'b1;
      vga_de    <= 1'b0;
      vga_red   <= '0;
      vga_grn   <= '0;
      vga_blu   <= '0;
    end else begin
      vga_hsync <= !hsync_on;
      vga_vsync <= !vsync_on;
      vga_de    <= visible;
      if (visible && display_en) begin
        {vga_red, vga_grn, vga_blu} <= rdata;
      end else begin
        vga_red <= '0;
        vga_grn <= '0;
        vga_blu <= '0;
      end
    end
  end

  // persistence, 0 behaves like 1
  assign persist_eff = (persist == '0) ? persist_bits'(1) : persist;
  assign swap_due    = frame_cnt >= (persist_eff - 1'b1);

  always_ff @(posedge clk) begin
    if (reset) begin
      frame_cnt <= '0;
      swap_req  <= 1'b0;
    end else begin
      swap_req <= frame_end && swap_due;
      if (frame_end) begin
        frame_cnt <= swap_due ? '0 : frame_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/fb_mem.sv
`timescale 1ns/1ps
`default_nettype none

module fb_mem (
  input  logic                clk,
  input  logic                reset,
  input  logic                swap,
  input  logic                we,
  input  scope_pkg::fb_addr_t waddr,
  input  scope_pkg::pixel_t   wdata,
  input  scope_pkg::fb_addr_t raddr,
  output scope_pkg::pixel_t   rdata
);
  import scope_pkg::*;

  pixel_t mem [2][fb_pixels];

  // front bank is scanned out while the back bank takes writes
  logic front_sel;
  logic back_sel;

  assign back_sel = ~front_sel;

  always_ff @(posedge clk) begin
    if (reset) begin
      front_sel <= 1'b0;
    end else if (swap) begin
      front_sel <= ~front_sel;
    end
  end

  // a write on the swap edge still goes to the old back bank
  always_ff @(posedge clk) begin
    if (we) begin
      mem[back_sel][waddr] <= wdata;
    end
  end

  // asynchronous read with the pixel registered in raster_scan
  assign rdata = mem[front_sel][raddr];

  // both writers stay inside the 768 visible pixels
  assert property (@(posedge clk) disable iff (reset)
    we |-> (waddr < fb_addr_t'(fb_pixels)))
    else $error("fb_mem: write address outside the bank");

endmodule

`default_nettype wire

//--- design/fb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module fb_arbiter (
  pix_wr_if.arbiter                clr,
  pix_wr_if.arbiter                plot,
  output logic                     we,
  output scope_pkg::fb_addr_t      waddr,
  output scope_pkg::pixel_t        wdata
);

  // clear always wins and plot waits behind it
  assign clr.ready  = 1'b1;
  assign plot.ready = !clr.valid;

  assign we    = clr.valid || plot.valid;
  assign waddr = clr.valid ? clr.addr : plot.addr;
  assign wdata = clr.valid ? clr.color : plot.color;

  // a plot request held back by the clear keeps its address and colour
  assert property (@(posedge plot.clk)
    (plot.valid && !plot.ready) |=>
      (plot.valid && $stable(plot.addr) && $stable(plot.color)))
    else $error("fb_arbiter: plot request changed while waiting");

endmodule

`default_nettype wire

//--- design/fb_clear.sv
`timescale 1ns/1ps
`default_nettype none

module fb_clear (
  input  logic              clk,
  input  logic              reset,
  input  logic              start,
  input  scope_pkg::pixel_t bg_color,
  output logic              busy,
  output logic              display_en,
  pix_wr_if.writer          wr
);
  import scope_pkg::*;

  fb_addr_t addr;
  logic     fire;
  logic     done;

  assign fire = wr.valid && wr.ready;
  assign done = fire && (addr == fb_addr_t'(fb_pixels - 1));

  assign wr.valid = busy;
  assign wr.addr  = addr;
  assign wr.color = bg_color;

  // sweep runs from reset and again from every swap
  always_ff @(posedge clk) begin
    if (reset || start) begin
      busy <= 1'b1;
      addr <= '0;
    end else if (fire) begin
      if (done) begin
        busy <= 1'b0;
      end else begin
        addr <= addr + 1'b1;
      end
    end
  end

  // first finished sweep unblanks the display
  always_ff @(posedge clk) begin
    if (reset) begin
      display_en <= 1'b0;
    end else if (done) begin
      display_en <= 1'b1;
    end
  end

endmodule

`default_nettype wire

//--- design/point_plotter.sv
`timescale 1ns/1ps
`default_nettype none

module point_plotter (
  input  logic                           clk,
  input  logic                           reset,
  input  logic [scope_pkg::adc_bits-1:0] adc_x,
  input  logic [scope_pkg::adc_bits-1:0] adc_y,
  input  logic                           adc_valid,
  output logic                           adc_ready,
  input  scope_pkg::pixel_t              plot_color,
  input  logic                           clear_busy,
  pix_wr_if.writer                       wr
);
  import scope_pkg::*;

  // stage 1, scaled sample
  logic                 s1_valid;
  logic [fb_x_bits-1:0] s1_x;
  logic [fb_y_bits-1:0] s1_y;

  logic s2_free;
  logic s1_free;
  logic take;
  logic s1_on_screen;

  // stage 2 is the write request itself
  assign s2_free      = !wr.valid || wr.ready;
  assign s1_free      = !s1_valid || s2_free;
  assign adc_ready    = s1_free && !clear_busy;
  assign take         = adc_valid && adc_ready;
  assign s1_on_screen = s1_y < fb_y_bits'(fb_height);

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid <= 1'b0;
    end else if (s1_free) begin
      s1_valid <= take;
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      s1_x <= fb_x_bits'(adc_x >> adc_shift);
      s1_y <= fb_y_bits'(adc_y >> adc_shift);
    end
  end

  // points below the visible area are dropped here
  always_ff @(posedge clk) begin
    if (reset) begin
      wr.valid <= 1'b0;
    end else if (s2_free) begin
      wr.valid <= s1_valid && s1_on_screen;
    end
  end

  always_ff @(posedge clk) begin
    if (s2_free && s1_valid) begin
      wr.addr  <= {s1_y, s1_x};
      wr.color <= plot_color;
    end
  end

endmodule

`default_nettype wire

//--- design/scope_regs.sv
`timescale 1ns/1ps
`default_nettype none

module scope_regs (
  input  logic                                clk,
  input  logic                                reset,
  input  logic [scope_pkg::apb_addr_bits-1:0] paddr,
  input  logic                                psel,
  input  logic                                penable,
  input  logic                                pwrite,
  input  logic [scope_pkg::apb_data_bits-1:0] pwdata,
  output logic [scope_pkg::apb_data_bits-1:0] prdata,
  output logic                                pready,
  output scope_pkg::pixel_t                   plot_color,
  output scope_pkg::pixel_t                   bg_color,
  output logic [ scope_pkg::persist_bits-1:0] persist
);
  import scope_pkg::*;

  logic wr_en;

  // no wait states
  assign pready = 1'b1;

  // writes land in the access phase
  assign wr_en = psel && penable && pwrite;

  always_ff @(posedge clk) begin
    if (reset) begin
      plot_color <= plot_color_init;
      bg_color   <= bg_color_init;
      persist    <= persist_init;
    end else if (wr_en) begin
      case (paddr)
        reg_plot_color: plot_color <= pwdata[pixel_bits-1:0];
        reg_bg_color:   bg_color   <= pwdata[pixel_bits-1:0];
        reg_persist:    persist    <= pwdata[persist_bits-1:0];
        default: ;
      endcase
    end
  end

  // read mux, unmapped offsets give 0
  always_comb begin
    case (paddr)
      reg_plot_color: prdata = apb_data_bits'(plot_color);
      reg_bg_color:   prdata = apb_data_bits'(bg_color);
      reg_persist:    prdata = apb_data_bits'(persist);
      default:        prdata = '0;
    endcase
  end

  // access phase only ever follows a selected setup phase
  assert property (@(posedge clk) disable iff (reset) penable |-> psel)
    else $error("scope_regs: penable without psel");

endmodule

`default_nettype wire

//--- design/pix_wr_if.sv
`timescale 1ns/1ps
`default_nettype none

// one pixel write request, valid/ready handshake
interface pix_wr_if (
  input logic clk
);
  import scope_pkg::*;

  fb_addr_t addr;
  pixel_t   color;
  logic     valid;
  logic     ready;

  // addr and color hold while valid waits for ready
  modport writer (
    output addr,
    output color,
    output valid,
    input  ready
  );

  modport arbiter (
    input  clk,
    input  addr,
    input  color,
    input  valid,
    output ready
  );

endinterface

`default_nettype wire

//--- design/scope_pkg.sv
`default_nettype none

package scope_pkg;

  // adc sample width
  localparam int adc_bits = 10;

  // visible framebuffer and full raster geometry
  localparam int fb_width  = 32;
  localparam int fb_height = 24;
  localparam int h_total   = 40;
  localparam int v_total   = 28;

  // sync pulse placement, both active low
  localparam int hsync_start = 33;
  localparam int hsync_len   = 4;
  localparam int vsync_start = 25;
  localparam int vsync_len   = 2;

  // raster counter widths
  localparam int h_cnt_bits = 6;
  localparam int v_cnt_bits = 5;

  // framebuffer addressing, addr = y * 32 + x
  localparam int fb_x_bits    = 5;
  localparam int fb_y_bits    = 5;
  localparam int fb_addr_bits = 10;
  localparam int fb_pixels    = fb_width * fb_height;

  // sample to pixel scaling
  localparam int adc_shift = adc_bits - fb_x_bits;

  // 4 bits each of red, green, blue
  localparam int pixel_bits   = 12;
  localparam int color_bits   = 4;
  localparam int persist_bits = 3;

  typedef logic [pixel_bits-1:0] pixel_t;
  typedef logic [fb_addr_bits-1:0] fb_addr_t;

  // apb register map
  localparam int apb_addr_bits = 4;
  localparam int apb_data_bits = 32;
  localparam logic [apb_addr_bits-1:0] reg_plot_color = 4'h0;
  localparam logic [apb_addr_bits-1:0] reg_bg_color   = 4'h4;
  localparam logic [apb_addr_bits-1:0] reg_persist    = 4'h8;

  // register reset values
  localparam pixel_t plot_color_init = 12'hfff;
  localparam pixel_t bg_color_init   = 12'h000;
  localparam logic [persist_bits-1:0] persist_init = 3'd1;

endpackage

`default_nettype wire
